// File: hdl/fmau_special_pkg.sv
package fmau_special_pkg;

  // ========================================
  // Format widths
  // ========================================
  localparam int SINGLE_EXPN = 8;
  localparam int DOUBLE_EXPN = 11;
  localparam int SINGLE_FRAC = 23;
  localparam int DOUBLE_FRAC = 52;

  // Upper word of a single result
  localparam logic [31:0] NAN_BOX = 32'hffff_ffff;

  typedef logic [63:0] data_t;
  // Biased product exponent, top bits give overflow and sign headroom
  typedef logic [12:0] expnt_t;
  typedef logic [2:0]  rm_t;
  // Invalid in bit 1, overflow in bit 0
  typedef logic [1:0]  fflags_t;
  // lfn, inf, zero, src2 from the top down
  typedef logic [3:0]  special_sign_t;

  // ========================================
  // Rounding modes
  // ========================================
  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;

  // Class of one operand in one format, subnormals count as norm
  typedef struct packed {
    logic snan;
    logic qnan;
    logic inf;
    logic zero;
    logic norm;
  } op_class_t;

  typedef struct packed {
    op_class_t dbl;
    op_class_t sgl;
  } src_type_t;

  typedef struct packed {
    logic      dst_double;
    logic      mac;
    rm_t       rm;
    logic      mult_sign;
    logic      src2_sign;
    expnt_t    mult_expnt;
  } ex1_op_t;

  // One-hot choice of the special result
  typedef struct packed {
    logic qnan;
    logic cnan;
    logic lfn;
    logic inf;
    logic zero;
    logic src2;
  } special_sel_t;

endpackage

// File: hdl/fmau_operand_class.sv
`timescale 1ns/1ps

module fmau_operand_class
(
  input  fmau_special_pkg::ex1_op_t   ex1_op,
  input  fmau_special_pkg::src_type_t ex1_srcv0_type,
  input  fmau_special_pkg::src_type_t ex1_srcv1_type,
  input  fmau_special_pkg::src_type_t ex1_srcv2_type,
  output fmau_special_pkg::op_class_t cls0,
  output fmau_special_pkg::op_class_t cls1,
  output fmau_special_pkg::op_class_t cls2
);

  import fmau_special_pkg::*;

  // A plain multiply adds an exact zero
  localparam op_class_t NO_MAC_CLASS = '{snan: 1'b0, qnan: 1'b0, inf: 1'b0,
                                         zero: 1'b1, norm: 1'b0};

  op_class_t cls2_view;

  // Destination view of each operand
  assign cls0      = ex1_op.dst_double ? ex1_srcv0_type.dbl : ex1_srcv0_type.sgl;
  assign cls1      = ex1_op.dst_double ? ex1_srcv1_type.dbl : ex1_srcv1_type.sgl;
  assign cls2_view = ex1_op.dst_double ? ex1_srcv2_type.dbl : ex1_srcv2_type.sgl;

  assign cls2 = ex1_op.mac ? cls2_view : NO_MAC_CLASS;

endmodule

// File: hdl/fmau_expnt_range.sv
`timescale 1ns/1ps

module fmau_expnt_range
(
  input  fmau_special_pkg::ex1_op_t   ex1_op,
  input  fmau_special_pkg::op_class_t cls0,
  input  fmau_special_pkg::op_class_t cls1,
  input  fmau_special_pkg::op_class_t cls2,
  output logic                        ex1_of
);

  import fmau_special_pkg::*;

  // First biased exponent past the largest finite one
  localparam expnt_t DBL_OF_EXPNT = expnt_t'(1) << DOUBLE_EXPN;
  localparam expnt_t SGL_OF_EXPNT = expnt_t'(1) << SINGLE_EXPN;

  expnt_t of_expnt;
  logic   mult_norm;
  logic   expnt_of_range;
  logic   expnt_at_max;

  assign of_expnt  = ex1_op.dst_double ? DBL_OF_EXPNT : SGL_OF_EXPNT;
  assign mult_norm = cls0.norm & cls1.norm;

  // Negative exponents have bit 12 set and fall above the window
  assign expnt_of_range = (ex1_op.mult_expnt >= of_expnt)
                        && (ex1_op.mult_expnt < (of_expnt << 1));

  // Top binade can still round over without an addend
  assign expnt_at_max = ex1_op.mult_expnt == (of_expnt - expnt_t'(1));

  assign ex1_of = mult_norm
                && ((expnt_of_range && (cls2.norm || cls2.zero))
                   || (expnt_at_max && !ex1_op.mac));

endmodule

// File: hdl/fmau_special_ctrl.sv
`timescale 1ns/1ps

module fmau_special_ctrl
(
  input  logic                            fmau_ex2_data_clk,
  input  logic                            rst_n,
  input  logic                            cp0_dqnan,
  input  logic                            ex1_pipe_down,
  input  logic                            ex2_pipe_down,
  input  fmau_special_pkg::ex1_op_t       ex1_op,
  input  fmau_special_pkg::op_class_t     cls0,
  input  fmau_special_pkg::op_class_t     cls1,
  input  fmau_special_pkg::op_class_t     cls2,
  input  logic                            ex1_of,
  output logic [2:0]                      ex1_nan_sel,
  output fmau_special_pkg::special_sel_t  ex2_special_sel,
  output fmau_special_pkg::special_sign_t ex2_special_sign,
  output logic                            ex3_special_data_vld,
  output fmau_special_pkg::fflags_t       ex3_special_fflags
);

  import fmau_special_pkg::*;

  logic [2:0]    snan;
  logic [2:0]    qnan;
  logic [2:0]    inf;
  logic [2:0]    zero;
  logic [2:0]    norm;
  logic          nan_win;
  logic          sub;
  logic          prod_inf;
  logic          prod_zero;
  logic          inf_x_zero;
  logic          inf_m_inf;
  logic          invalid;
  logic          of_to_inf;
  logic          of_to_lfn;
  special_sel_t  ex1_sel;
  special_sign_t ex1_sign;
  fflags_t       ex2_fflags;

  assign snan = {cls2.snan, cls1.snan, cls0.snan};
  assign qnan = {cls2.qnan, cls1.qnan, cls0.qnan};
  assign inf  = {cls2.inf,  cls1.inf,  cls0.inf};
  assign zero = {cls2.zero, cls1.zero, cls0.zero};
  assign norm = {cls2.norm, cls1.norm, cls0.norm};

  // ========================================
  // EX1 decision
  // ========================================
  // Lowest-numbered sNaN first, then lowest-numbered qNaN
  assign ex1_nan_sel = (|snan) ? (snan & (~snan + 3'd1)) : (qnan & (~qnan + 3'd1));
  assign nan_win     = |ex1_nan_sel;

  assign sub       = (ex1_op.mult_sign ^ ex1_op.src2_sign) && ex1_op.mac;
  assign prod_inf  = (inf[0] && (inf[1] || norm[1])) || (inf[1] && norm[0]);
  assign prod_zero = (zero[0] && (zero[1] || norm[1])) || (zero[1] && norm[0]);

  assign inf_x_zero = (inf[0] && zero[1]) || (inf[1] && zero[0]);
  assign inf_m_inf  = prod_inf && inf[2] && sub;
  assign invalid    = (|snan) || inf_x_zero || inf_m_inf;

  // Overflow goes to inf or lfn by direction of rounding
  assign of_to_inf = (ex1_op.rm == RM_RNE) || (ex1_op.rm == RM_RMM)
                   || ((ex1_op.rm == RM_RDN) && ex1_op.mult_sign)
                   || ((ex1_op.rm == RM_RUP) && !ex1_op.mult_sign);
  assign of_to_lfn = (ex1_op.rm == RM_RTZ)
                   || ((ex1_op.rm == RM_RDN) && !ex1_op.mult_sign)
                   || ((ex1_op.rm == RM_RUP) && ex1_op.mult_sign);

  assign ex1_sel.qnan = nan_win && cp0_dqnan;
  assign ex1_sel.cnan = (nan_win && !cp0_dqnan) || inf_m_inf
                      || (inf_x_zero && !ex1_nan_sel[2]);
  assign ex1_sel.lfn  = ex1_of && of_to_lfn;
  assign ex1_sel.inf  = ((|inf) && !nan_win && !inf_x_zero && !inf_m_inf)
                      || (ex1_of && of_to_inf);
  assign ex1_sel.zero = prod_zero && zero[2];
  assign ex1_sel.src2 = prod_zero && norm[2];

  // lfn, inf, zero, src2
  assign ex1_sign[3] = ex1_op.mult_sign;
  assign ex1_sign[2] = (inf[0] || inf[1] || ex1_of) ? ex1_op.mult_sign : ex1_op.src2_sign;
  assign ex1_sign[1] = sub ? (ex1_op.rm == RM_RDN) : ex1_op.mult_sign;
  assign ex1_sign[0] = ex1_op.src2_sign;

  // ========================================
  // Stage registers
  // ========================================
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      ex2_special_sel <= '0;
      ex2_fflags      <= '0;
    end
    else if (ex1_pipe_down)
    begin
      ex2_special_sel <= ex1_sel;
      ex2_fflags      <= {invalid, ex1_of};
    end
  end

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (ex1_pipe_down)
      ex2_special_sign <= ex1_sign;
  end

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      ex3_special_data_vld <= 1'b0;
      ex3_special_fflags   <= '0;
    end
    else if (ex2_pipe_down)
    begin
      ex3_special_data_vld <= |ex2_special_sel;
      ex3_special_fflags   <= ex2_fflags;
    end
  end

endmodule

// File: hdl/fmau_nan_payload.sv
`timescale 1ns/1ps

module fmau_nan_payload
(
  input  logic                    fmau_ex2_data_clk,
  input  logic                    ex1_pipe_down,
  input  logic [2:0]              ex1_nan_sel,
  input  fmau_special_pkg::data_t ex1_srcv0,
  input  fmau_special_pkg::data_t ex1_srcv1,
  input  fmau_special_pkg::data_t ex1_srcv2,
  output fmau_special_pkg::data_t ex2_special_data
);

  import fmau_special_pkg::*;

  data_t ex1_special_data;

  // Addend bits also serve the src2 result when no NaN wins
  always_comb
  begin
    case (ex1_nan_sel)
      3'b001:  ex1_special_data = ex1_srcv0;
      3'b010:  ex1_special_data = ex1_srcv1;
      default: ex1_special_data = ex1_srcv2;
    endcase
  end

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (ex1_pipe_down)
      ex2_special_data <= ex1_special_data;
  end

endmodule

// File: hdl/fmau_result_pack.sv
`timescale 1ns/1ps

module fmau_result_pack
(
  input  logic                            fmau_ex2_data_clk,
  input  logic                            ex1_pipe_down,
  input  logic                            ex2_pipe_down,
  input  fmau_special_pkg::ex1_op_t       ex1_op,
  input  fmau_special_pkg::special_sel_t  ex2_special_sel,
  input  fmau_special_pkg::special_sign_t ex2_special_sign,
  input  fmau_special_pkg::data_t         ex2_special_data,
  output fmau_special_pkg::data_t         ex3_special_result
);

  import fmau_special_pkg::*;

  logic        ex2_dst_double;
  data_t       dbl_result;
  logic [31:0] sgl_result;
  data_t       ex2_special_result;

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (ex1_pipe_down)
      ex2_dst_double <= ex1_op.dst_double;
  end

  // ========================================
  // Encodings per format
  // ========================================
  always_comb
  begin
    unique case (1'b1)
      ex2_special_sel.src2:
      begin
        dbl_result = {ex2_special_sign[0], ex2_special_data[62:0]};
        sgl_result = {ex2_special_sign[0], ex2_special_data[30:0]};
      end
      ex2_special_sel.zero:
      begin
        dbl_result = {ex2_special_sign[1], 63'b0};
        sgl_result = {ex2_special_sign[1], 31'b0};
      end
      ex2_special_sel.inf:
      begin
        dbl_result = {ex2_special_sign[2], {DOUBLE_EXPN{1'b1}}, {DOUBLE_FRAC{1'b0}}};
        sgl_result = {ex2_special_sign[2], {SINGLE_EXPN{1'b1}}, {SINGLE_FRAC{1'b0}}};
      end
      ex2_special_sel.lfn:
      begin
        dbl_result = {ex2_special_sign[3], {(DOUBLE_EXPN-1){1'b1}}, 1'b0,
                      {DOUBLE_FRAC{1'b1}}};
        sgl_result = {ex2_special_sign[3], {(SINGLE_EXPN-1){1'b1}}, 1'b0,
                      {SINGLE_FRAC{1'b1}}};
      end
      ex2_special_sel.cnan:
      begin
        dbl_result = {1'b0, {DOUBLE_EXPN{1'b1}}, 1'b1, {(DOUBLE_FRAC-1){1'b0}}};
        sgl_result = {1'b0, {SINGLE_EXPN{1'b1}}, 1'b1, {(SINGLE_FRAC-1){1'b0}}};
      end
      ex2_special_sel.qnan:
      begin
        // Payload kept, quiet bit forced
        dbl_result = {ex2_special_data[63], {DOUBLE_EXPN{1'b1}}, 1'b1,
                      ex2_special_data[DOUBLE_FRAC-2:0]};
        sgl_result = {ex2_special_data[31], {SINGLE_EXPN{1'b1}}, 1'b1,
                      ex2_special_data[SINGLE_FRAC-2:0]};
      end
      default:
      begin
        dbl_result = '0;
        sgl_result = '0;
      end
    endcase
  end

  assign ex2_special_result = ex2_dst_double ? dbl_result : {NAN_BOX, sgl_result};

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (ex2_pipe_down)
      ex3_special_result <= ex2_special_result;
  end

endmodule

// File: hdl/fmau_special_top.sv
`timescale 1ns/1ps

module fmau_special_top
(
  input  logic                           fmau_ex2_data_clk,
  input  logic                           rst_n,
  input  logic                           cp0_dqnan,
  input  logic                           ex1_pipe_down,
  input  logic                           ex2_pipe_down,
  input  fmau_special_pkg::ex1_op_t      ex1_op,
  input  fmau_special_pkg::data_t        ex1_srcv0,
  input  fmau_special_pkg::data_t        ex1_srcv1,
  input  fmau_special_pkg::data_t        ex1_srcv2,
  input  fmau_special_pkg::src_type_t    ex1_srcv0_type,
  input  fmau_special_pkg::src_type_t    ex1_srcv1_type,
  input  fmau_special_pkg::src_type_t    ex1_srcv2_type,
  output fmau_special_pkg::special_sel_t ex2_special_sel,
  output logic                           ex3_special_data_vld,
  output fmau_special_pkg::fflags_t      ex3_special_fflags,
  output fmau_special_pkg::data_t        ex3_special_result
);

  import fmau_special_pkg::*;

  op_class_t     cls0;
  op_class_t     cls1;
  op_class_t     cls2;
  logic          ex1_of;
  logic [2:0]    ex1_nan_sel;
  special_sign_t ex2_special_sign;
  data_t         ex2_special_data;

  fmau_operand_class u_operand_class
  (
    .ex1_op         (ex1_op),
    .ex1_srcv0_type (ex1_srcv0_type),
    .ex1_srcv1_type (ex1_srcv1_type),
    .ex1_srcv2_type (ex1_srcv2_type),
    .cls0           (cls0),
    .cls1           (cls1),
    .cls2           (cls2)
  );

  fmau_expnt_range u_expnt_range
  (
    .ex1_op (ex1_op),
    .cls0   (cls0),
    .cls1   (cls1),
    .cls2   (cls2),
    .ex1_of (ex1_of)
  );

  fmau_special_ctrl u_special_ctrl
  (
    .fmau_ex2_data_clk    (fmau_ex2_data_clk),
    .rst_n                (rst_n),
    .cp0_dqnan            (cp0_dqnan),
    .ex1_pipe_down        (ex1_pipe_down),
    .ex2_pipe_down        (ex2_pipe_down),
    .ex1_op               (ex1_op),
    .cls0                 (cls0),
    .cls1                 (cls1),
    .cls2                 (cls2),
    .ex1_of               (ex1_of),
    .ex1_nan_sel          (ex1_nan_sel),
    .ex2_special_sel      (ex2_special_sel),
    .ex2_special_sign     (ex2_special_sign),
    .ex3_special_data_vld (ex3_special_data_vld),
    .ex3_special_fflags   (ex3_special_fflags)
  );

  fmau_nan_payload u_nan_payload
  (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .ex1_pipe_down     (ex1_pipe_down),
    .ex1_nan_sel       (ex1_nan_sel),
    .ex1_srcv0         (ex1_srcv0),
    .ex1_srcv1         (ex1_srcv1),
    .ex1_srcv2         (ex1_srcv2),
    .ex2_special_data  (ex2_special_data)
  );

  fmau_result_pack u_result_pack
  (
    .fmau_ex2_data_clk  (fmau_ex2_data_clk),
    .ex1_pipe_down      (ex1_pipe_down),
    .ex2_pipe_down      (ex2_pipe_down),
    .ex1_op             (ex1_op),
    .ex2_special_sel    (ex2_special_sel),
    .ex2_special_sign   (ex2_special_sign),
    .ex2_special_data   (ex2_special_data),
    .ex3_special_result (ex3_special_result)
  );

endmodule

// File: bench/fmau_special_checker.sv
`timescale 1ns/1ps

module fmau_special_checker
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cp0_dqnan,
  input  logic                           ex1_pipe_down,
  input  logic                           ex2_pipe_down,
  input  fmau_special_pkg::ex1_op_t      ex1_op,
  input  fmau_special_pkg::data_t        ex1_srcv0,
  input  fmau_special_pkg::data_t        ex1_srcv1,
  input  fmau_special_pkg::data_t        ex1_srcv2,
  input  fmau_special_pkg::src_type_t    ex1_srcv0_type,
  input  fmau_special_pkg::src_type_t    ex1_srcv1_type,
  input  fmau_special_pkg::src_type_t    ex1_srcv2_type,
  input  fmau_special_pkg::special_sel_t ex2_special_sel,
  input  logic                           ex3_special_data_vld,
  input  fmau_special_pkg::fflags_t      ex3_special_fflags,
  input  fmau_special_pkg::data_t        ex3_special_result,
  output int                             check_count,
  output int                             error_count
);

  import fmau_special_pkg::*;

  typedef struct packed {
    special_sel_t sel;
    logic         vld;
    fflags_t      flags;
    data_t        result;
  } expect_t;

  expect_t ex2_exp;
  expect_t ex3_exp;
  logic    armed;

  // Exponent right-aligned, fraction top-aligned to 52 bits
  function automatic data_t encode(input logic dbl, input logic sign,
                                   input logic [10:0] ex, input logic [51:0] fr);
    if (dbl)
      return {sign, ex, fr};
    return {NAN_BOX, sign, ex[7:0], fr[51:29]};
  endfunction

  function automatic expect_t ref_special(input ex1_op_t op, input src_type_t t0,
                                          input src_type_t t1, input src_type_t t2,
                                          input data_t s0, input data_t s1,
                                          input data_t s2, input logic dqnan);
    op_class_t c0;
    op_class_t c1;
    op_class_t c2;
    logic      sub;
    logic      of;
    logic      ixz;
    logic      imi;
    logic      pinf;
    logic      pzero;
    logic      any_snan;
    logic      nan_found;
    logic      up;
    data_t     pay;
    expnt_t    lo;
    expect_t   r;
    c0 = op.dst_double ? t0.dbl : t0.sgl;
    c1 = op.dst_double ? t1.dbl : t1.sgl;
    c2 = op.dst_double ? t2.dbl : t2.sgl;
    if (!op.mac)
    begin
      c2      = '0;
      c2.zero = 1'b1;
    end
    lo  = expnt_t'(1) << (op.dst_double ? 11 : 8);
    sub = op.mac && (op.mult_sign != op.src2_sign);
    of  = c0.norm && c1.norm
        && (((op.mult_expnt >= lo) && (op.mult_expnt < (lo << 1)) && (c2.norm || c2.zero))
           || (!op.mac && (op.mult_expnt == lo - expnt_t'(1))));
    ixz   = (c0.inf && c1.zero) || (c1.inf && c0.zero);
    pinf  = (c0.inf && (c1.inf || c1.norm)) || (c1.inf && (c0.inf || c0.norm));
    pzero = (c0.zero && (c1.zero || c1.norm)) || (c1.zero && (c0.zero || c0.norm));
    imi   = pinf && c2.inf && sub;
    any_snan  = c0.snan || c1.snan || c2.snan;
    nan_found = 1'b1;
    // NaN priority
    if (c0.snan) pay = s0;
    else if (c1.snan) pay = s1;
    else if (c2.snan) pay = s2;
    else if (c0.qnan) pay = s0;
    else if (c1.qnan) pay = s1;
    else if (c2.qnan) pay = s2;
    else
    begin
      pay       = s2;
      nan_found = 1'b0;
    end
    up = (op.rm == RM_RNE) || (op.rm == RM_RMM)
       || ((op.rm == RM_RDN) && op.mult_sign) || ((op.rm == RM_RUP) && !op.mult_sign);
    r.sel   = '0;
    r.vld   = 1'b1;
    r.flags = {any_snan || ixz || imi, of};
    if (nan_found && dqnan)
    begin
      r.sel.qnan = 1'b1;
      if (op.dst_double)
        r.result = {pay[63], 11'h7ff, 1'b1, pay[50:0]};
      else
        r.result = {NAN_BOX, pay[31], 8'hff, 1'b1, pay[21:0]};
    end
    else if (nan_found || imi || ixz)
    begin
      r.sel.cnan = 1'b1;
      r.result   = encode(op.dst_double, 1'b0, 11'h7ff, 52'h8_0000_0000_0000);
    end
    else if (of && up)
    begin
      r.sel.inf = 1'b1;
      r.result  = encode(op.dst_double, op.mult_sign, 11'h7ff, '0);
    end
    else if (of)
    begin
      r.sel.lfn = 1'b1;
      r.result  = encode(op.dst_double, op.mult_sign, 11'h7fe, '1);
    end
    else if (c0.inf || c1.inf || c2.inf)
    begin
      r.sel.inf = 1'b1;
      r.result  = encode(op.dst_double, (c0.inf || c1.inf) ? op.mult_sign : op.src2_sign,
                         11'h7ff, '0);
    end
    else if (pzero && c2.zero)
    begin
      r.sel.zero = 1'b1;
      r.result   = encode(op.dst_double, sub ? (op.rm == RM_RDN) : op.mult_sign, '0, '0);
    end
    else if (pzero && c2.norm)
    begin
      r.sel.src2 = 1'b1;
      r.result   = op.dst_double ? {op.src2_sign, s2[62:0]}
                                 : {NAN_BOX, op.src2_sign, s2[30:0]};
    end
    else
    begin
      r.vld    = 1'b0;
      r.result = '0;
    end
    return r;
  endfunction

  // Expected values follow the same strobes as the DUT stages
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      ex2_exp = '0;
      ex3_exp = '0;
      armed   = 1'b0;
    end
    else
    begin
      if (ex2_pipe_down)
        ex3_exp = ex2_exp;
      if (ex1_pipe_down)
        ex2_exp = ref_special(ex1_op, ex1_srcv0_type, ex1_srcv1_type, ex1_srcv2_type,
                              ex1_srcv0, ex1_srcv1, ex1_srcv2, cp0_dqnan);
      armed = 1'b1;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      check_count = 0;
      error_count = 0;
    end
    else if (armed)
    begin
      check_count++;
      if (ex2_special_sel !== ex2_exp.sel)
      begin
        $display("CHECK FAILED ex2_special_sel: got %h expected %h",
                 ex2_special_sel, ex2_exp.sel);
        error_count++;
      end
      if (ex3_special_data_vld !== ex3_exp.vld)
      begin
        $display("CHECK FAILED ex3_special_data_vld: got %h expected %h",
                 ex3_special_data_vld, ex3_exp.vld);
        error_count++;
      end
      if (ex3_special_fflags !== ex3_exp.flags)
      begin
        $display("CHECK FAILED ex3_special_fflags: got %h expected %h",
                 ex3_special_fflags, ex3_exp.flags);
        error_count++;
      end
      if (ex3_exp.vld && (ex3_special_result !== ex3_exp.result))
      begin
        $display("CHECK FAILED ex3_special_result: got %h expected %h",
                 ex3_special_result, ex3_exp.result);
        error_count++;
      end
    end
  end

endmodule

// File: bench/fmau_special_props.sv
`timescale 1ns/1ps

module fmau_special_props
(
  input logic                           clk,
  input logic                           rst_n,
  input fmau_special_pkg::special_sel_t sel,
  input fmau_special_pkg::fflags_t      ex2_fflags,
  input logic                           vld,
  input fmau_special_pkg::fflags_t      fflags
);

  import fmau_special_pkg::*;

  sel_at_most_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(sel))
    else $error("special selection has more than one bit set: %b", sel);

  // Reset clears the selection, valid and flags
  state_clear_after_reset: assert property (@(posedge clk)
    !rst_n |=> (sel == '0) && !vld && (fflags == '0))
    else $error("state not clear in the cycle after reset");

  invalid_gives_nan: assert property (@(posedge clk) disable iff (!rst_n)
    ex2_fflags[1] |-> (sel.qnan || sel.cnan))
    else $error("invalid flag without a NaN selection");

endmodule

bind fmau_special_ctrl fmau_special_props u_props
(
  .clk        (fmau_ex2_data_clk),
  .rst_n      (rst_n),
  .sel        (ex2_special_sel),
  .ex2_fflags (ex2_fflags),
  .vld        (ex3_special_data_vld),
  .fflags     (ex3_special_fflags)
);

// File: bench/fmau_special_tb.sv
`timescale 1ns/1ps

module fmau_special_tb;

  import fmau_special_pkg::*;

  localparam int OPS            = 60;
  localparam int TESTS          = 6;
  localparam int TIMEOUT_CYCLES = TESTS * OPS + 40;

  logic         clk;
  logic         rst_n;
  logic         cp0_dqnan;
  logic         ex1_pipe_down;
  logic         ex2_pipe_down;
  ex1_op_t      ex1_op;
  data_t        ex1_srcv0;
  data_t        ex1_srcv1;
  data_t        ex1_srcv2;
  src_type_t    ex1_srcv0_type;
  src_type_t    ex1_srcv1_type;
  src_type_t    ex1_srcv2_type;
  special_sel_t ex2_special_sel;
  logic         ex3_special_data_vld;
  fflags_t      ex3_special_fflags;
  data_t        ex3_special_result;
  int           check_count;
  int           error_count;
  logic [31:0]  seed;
  int           cycles;
  string        names [1:6];

  fmau_special_top u_dut
  (
    .fmau_ex2_data_clk    (clk),
    .rst_n                (rst_n),
    .cp0_dqnan            (cp0_dqnan),
    .ex1_pipe_down        (ex1_pipe_down),
    .ex2_pipe_down        (ex2_pipe_down),
    .ex1_op               (ex1_op),
    .ex1_srcv0            (ex1_srcv0),
    .ex1_srcv1            (ex1_srcv1),
    .ex1_srcv2            (ex1_srcv2),
    .ex1_srcv0_type       (ex1_srcv0_type),
    .ex1_srcv1_type       (ex1_srcv1_type),
    .ex1_srcv2_type       (ex1_srcv2_type),
    .ex2_special_sel      (ex2_special_sel),
    .ex3_special_data_vld (ex3_special_data_vld),
    .ex3_special_fflags   (ex3_special_fflags),
    .ex3_special_result   (ex3_special_result)
  );

  fmau_special_checker u_chk
  (
    .clk                  (clk),
    .rst_n                (rst_n),
    .cp0_dqnan            (cp0_dqnan),
    .ex1_pipe_down        (ex1_pipe_down),
    .ex2_pipe_down        (ex2_pipe_down),
    .ex1_op               (ex1_op),
    .ex1_srcv0            (ex1_srcv0),
    .ex1_srcv1            (ex1_srcv1),
    .ex1_srcv2            (ex1_srcv2),
    .ex1_srcv0_type       (ex1_srcv0_type),
    .ex1_srcv1_type       (ex1_srcv1_type),
    .ex1_srcv2_type       (ex1_srcv2_type),
    .ex2_special_sel      (ex2_special_sel),
    .ex3_special_data_vld (ex3_special_data_vld),
    .ex3_special_fflags   (ex3_special_fflags),
    .ex3_special_result   (ex3_special_result),
    .check_count          (check_count),
    .error_count          (error_count)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Class codes 0 snan, 1 qnan, 2 inf, 3 zero, 4 norm
  function automatic op_class_t class_of(input int k);
    op_class_t c;
    c = '0;
    case (k)
      0:       c.snan = 1'b1;
      1:       c.qnan = 1'b1;
      2:       c.inf  = 1'b1;
      3:       c.zero = 1'b1;
      default: c.norm = 1'b1;
    endcase
    return c;
  endfunction

  task automatic make_operand(input logic dbl, input int k, output data_t d,
                              output src_type_t t);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [10:0] ex;
    logic [51:0] fr;
    op_class_t   other;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    fr = {r0[19:0], r1};
    ex = dbl ? 11'(r2[10:0] % 11'h7ff) : {3'b0, 8'(r2[7:0] % 8'hff)};
    case (k)
      0:
      begin
        ex     = '1;
        fr[51] = 1'b0;
        fr[29] = 1'b1;
        fr[0]  = 1'b1;
      end
      1:
      begin
        ex     = '1;
        fr[51] = 1'b1;
      end
      2:
      begin
        ex = '1;
        fr = '0;
      end
      3:
      begin
        ex = '0;
        fr = '0;
      end
      default: ;
    endcase
    d = dbl ? {r2[31], ex, fr} : {NAN_BOX, r2[31], ex[7:0], fr[51:29]};
    // The unused view carries an unrelated class
    other = class_of(int'(r2[30:28]) % 5);
    t.dbl = dbl ? class_of(k) : other;
    t.sgl = dbl ? other : class_of(k);
  endtask

  task automatic issue_op(input int id);
    logic [31:0] r;
    logic [31:0] c;
    int          k0;
    int          k1;
    int          k2;
    int          tmp;
    expnt_t      lo;
    ex1_op_t     op;
    r = next_rand();
    c = next_rand();
    op.dst_double = (id == 5) ? 1'b0 : r[0];
    op.mac        = r[1] | r[2];
    op.rm         = rm_t'(r[7:4] % 4'd5);
    op.mult_sign  = r[8];
    op.src2_sign  = r[9];
    op.mult_expnt = r[28:16];
    cp0_dqnan     = r[10];
    lo = expnt_t'(1) << (op.dst_double ? 11 : 8);
    k0 = int'(c[5:0]) % 5;
    k1 = int'(c[11:6]) % 5;
    k2 = int'(c[17:12]) % 5;
    case (id)
      1:
      begin
        // Lean towards NaN classes
        if (c[19:18] != 2'b00) k0 = int'(c[0]);
        if (c[21:20] != 2'b00) k1 = int'(c[6]);
        if (c[23:22] != 2'b00) k2 = int'(c[12]);
      end
      2:
      begin
        k0     = 2 + int'(c[5:0]) % 3;
        k1     = 2 + int'(c[11:6]) % 3;
        k2     = 2 + int'(c[17:12]) % 3;
        op.mac = 1'b1;
      end
      3:
      begin
        k0 = 3;
        k1 = c[0] ? 3 : 4;
        k2 = c[1] ? 3 : 4;
        if (c[2])
        begin
          tmp = k0;
          k0  = k1;
          k1  = tmp;
        end
      end
      4:
      begin
        k0 = 4;
        k1 = 4;
        k2 = c[0] ? 3 : 4;
      end
      default: ;
    endcase
    if ((id == 4) || (id == 5))
    begin
      case (c[26:24] % 3'd6)
        3'd0:    op.mult_expnt = lo - expnt_t'(2);
        3'd1:    op.mult_expnt = lo - expnt_t'(1);
        3'd2:    op.mult_expnt = lo;
        3'd3:    op.mult_expnt = (lo << 1) - expnt_t'(1);
        3'd4:    op.mult_expnt = lo << 1;
        default: ;
      endcase
    end
    ex1_pipe_down = (id == 6) ? (c[27] | c[28]) : 1'b1;
    ex2_pipe_down = (id == 6) ? (c[29] | c[30]) : 1'b1;
    ex1_op = op;
    make_operand(op.dst_double, k0, ex1_srcv0, ex1_srcv0_type);
    make_operand(op.dst_double, k1, ex1_srcv1, ex1_srcv1_type);
    make_operand(op.dst_double, k2, ex1_srcv2, ex1_srcv2_type);
  endtask

  task automatic run_test(input int id);
    int checks0;
    int errors0;
    checks0 = check_count;
    errors0 = error_count;
    for (int i = 0; i < OPS; i++)
    begin
      @(posedge clk);
      #2;
      issue_op(id);
    end
    // Drain both stages
    repeat (3)
    begin
      @(posedge clk);
      #2;
      ex1_pipe_down = 1'b1;
      ex2_pipe_down = 1'b1;
    end
    @(negedge clk);
    $display("test %0d %s: %0d checks, %0d errors", id, names[id],
             check_count - checks0, error_count - errors0);
  endtask

  initial
  begin
    names[1]       = "nan priority";
    names[2]       = "invalid operations";
    names[3]       = "zero products";
    names[4]       = "overflow rounding";
    names[5]       = "single format";
    names[6]       = "streaming stalls";
    seed           = 32'h04208fa6;
    cycles         = 0;
    clk            = 1'b0;
    rst_n          = 1'b0;
    cp0_dqnan      = 1'b0;
    ex1_pipe_down  = 1'b0;
    ex2_pipe_down  = 1'b0;
    ex1_op         = '0;
    ex1_srcv0      = '0;
    ex1_srcv1      = '0;
    ex1_srcv2      = '0;
    ex1_srcv0_type = '0;
    ex1_srcv1_type = '0;
    ex1_srcv2_type = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int id = 1; id <= TESTS; id++)
      run_test(id);
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: list.f
hdl/fmau_special_pkg.sv
hdl/fmau_operand_class.sv
hdl/fmau_expnt_range.sv
hdl/fmau_special_ctrl.sv
hdl/fmau_nan_payload.sv
hdl/fmau_result_pack.sv
hdl/fmau_special_top.sv
bench/fmau_special_checker.sv
bench/fmau_special_props.sv
bench/fmau_special_tb.sv

// File: Makefile
TOOL      = verilator
TOP       = fmau_special_tb
FILELIST  = list.f
LOG       = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
